//--- project.f
common/router_cfg_pkg.sv
common/router_types_pkg.sv
common/lane_if.sv
verilog/cluster_clock_gating.sv
fifo/generic_fifo_adv.sv
verilog/dest_decoder.sv
verilog/rr_allocator.sv
verilog/req_router_top.sv
tests/tb_req_router.sv

//--- Bender.yml
package:
  name: req_router

sources:
  # Packages and interface first
  - common/router_cfg_pkg.sv
  - common/router_types_pkg.sv
  - common/lane_if.sv
  # Design
  - verilog/cluster_clock_gating.sv
  - fifo/generic_fifo_adv.sv
  - verilog/dest_decoder.sv
  - verilog/rr_allocator.sv
  - verilog/req_router_top.sv
  # Testbench
  - target: test
    files:
      - tests/tb_req_router.sv

//--- tests/tb_req_router.sv
`timescale 1ns/1ns

module tb_req_router
   import router_cfg_pkg::*;
   import router_types_pkg::*;
();

   localparam int unsigned LANE_W       = $clog2(N_LANES);
   localparam int          RESET_CYCLES = 16;
   localparam logic [31:0] LFSR_SEED    = 32'h4082_087a;
   // x^32 + x^22 + x^2 + x + 1
   localparam logic [31:0] LFSR_POLY    = 32'h8020_0003;

   // Test lengths in cycles, random test in requests
   localparam int LEN_CLEAR = 40;
   localparam int LEN_BP    = 40;
   localparam int LEN_RR    = 80;
   localparam int RAND_REQS = 300;
   localparam int WATCHDOG_CYCLES =
      (LEN_CLEAR + LEN_BP + LEN_RR + RAND_REQS) * FIFO_DEPTH * N_LANES + RESET_CYCLES + 500;

   // One queued request as the scoreboard sees it
   typedef struct packed
   {
      req_op_e                op;
      logic [ADDR_WIDTH-1:0]  addr;
      logic [DATA_WIDTH-1:0]  wdata;
   } req_t;

   logic                   clk = 1'b0;
   logic                   rst_n;
   logic                   clear_i;
   logic                   test_mode_i;
   req_op_e                in_op_i;
   logic [ADDR_WIDTH-1:0]  in_addr_i;
   logic [DATA_WIDTH-1:0]  in_wdata_i;
   logic                   in_valid_i;
   logic                   in_grant_o;
   req_op_e                out_op_o;
   logic [ADDR_WIDTH-1:0]  out_addr_o;
   logic [DATA_WIDTH-1:0]  out_wdata_o;
   logic [LANE_W-1:0]      out_lane_o;
   logic                   out_valid_o;
   logic                   out_grant_i;

   // Accepted requests per lane, oldest first
   req_t                   sb_q [N_LANES][$];
   // Input transfer seen on the last rising edge
   logic                   in_fire = 1'b0;
   logic                   clear_d = 1'b0;
   // Model of the round-robin pointer
   logic [LANE_W-1:0]      rr_exp = '0;
   logic [31:0]            lfsr_state = LFSR_SEED;
   int                     err_count = 0;
   int                     tests_ok = 0;
   int                     tests_bad = 0;

   req_router_top #(
      .N_LANES      (N_LANES),
      .ADDR_WIDTH   (ADDR_WIDTH),
      .DATA_WIDTH   (DATA_WIDTH),
      .FIFO_DEPTH   (FIFO_DEPTH),
      .LANE_SEL_LSB (LANE_SEL_LSB)
   ) u_req_router_top (
      .clk         (clk),
      .rst_n       (rst_n),
      .clear_i     (clear_i),
      .test_mode_i (test_mode_i),
      .in_op_i     (in_op_i),
      .in_addr_i   (in_addr_i),
      .in_wdata_i  (in_wdata_i),
      .in_valid_i  (in_valid_i),
      .in_grant_o  (in_grant_o),
      .out_op_o    (out_op_o),
      .out_addr_o  (out_addr_o),
      .out_wdata_o (out_wdata_o),
      .out_lane_o  (out_lane_o),
      .out_valid_o (out_valid_o),
      .out_grant_i (out_grant_i)
   );

   always #50 clk = ~clk;

   // Galois step, one output bit per call of the inner loop
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      logic        lsb;
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         lsb        = lfsr_state[0];
         lfsr_state = lfsr_state >> 1;
         if (lsb)
         begin
            lfsr_state = lfsr_state ^ LFSR_POLY;
         end
         val = {val[30:0], lsb};
      end
      return val;
   endfunction

   // Lane select field of an address
   function automatic logic [LANE_W-1:0] lane_of(input logic [ADDR_WIDTH-1:0] addr);
      return addr[LANE_SEL_LSB +: LANE_W];
   endfunction

   // Random address forced onto one lane
   function automatic logic [ADDR_WIDTH-1:0] make_addr(input int lane);
      logic [ADDR_WIDTH-1:0] a;
      a = ADDR_WIDTH'(rand_bits(32));
      a[LANE_SEL_LSB +: LANE_W] = LANE_W'(lane);
      return a;
   endfunction

   function automatic int queued_total();
      int total;
      total = 0;
      foreach (sb_q[k])
      begin
         total += sb_q[k].size();
      end
      return total;
   endfunction

   task automatic check_true(input bit cond, input string what);
      if (!cond)
      begin
         $display("** %s", what);
         err_count++;
      end
   endtask

   // Called on a falling edge, returns on one
   task automatic send_req(input logic [ADDR_WIDTH-1:0] addr, input int max_wait, output bit ok);
      in_op_i    = req_op_e'(rand_bits(1));
      in_addr_i  = addr;
      in_wdata_i = DATA_WIDTH'(rand_bits(32));
      in_valid_i = 1'b1;
      ok = 1'b0;
      for (int i = 0; i < max_wait && !ok; i++)
      begin
         @(negedge clk);
         ok = in_fire;
      end
      in_valid_i = 1'b0;
   endtask

   task automatic wait_drained(input int max_cycles, output bit ok);
      ok = (queued_total() == 0);
      for (int i = 0; i < max_cycles && !ok; i++)
      begin
         @(negedge clk);
         ok = (queued_total() == 0);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (err_count == errs_before)
      begin
         $display("test %s: ok", name);
         tests_ok++;
      end
      else
      begin
         $display("test %s: FAILED with %0d errors", name, err_count - errs_before);
         tests_bad++;
      end
   endtask

   always @(posedge clk)
   begin
      clear_d <= clear_i;
   end

   // Idle outputs during reset and on the cycle after a clear
   a_idle: assert property (@(posedge clk) (!rst_n || clear_d) |-> (!out_valid_o && in_grant_o))
      else
      begin
         $display("** Error: out_valid_o = 0x%h, in_grant_o = 0x%h when idle, expected 0x0 and 0x1",
            $sampled(out_valid_o), $sampled(in_grant_o));
         err_count++;
      end

   // Output tag is the lane select field of the address
   a_lane_tag: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid_o |-> (out_lane_o == lane_of(out_addr_o)))
      else
      begin
         $display("** Error: out_lane_o = 0x%h, expected 0x%h",
            $sampled(out_lane_o), lane_of($sampled(out_addr_o)));
         err_count++;
      end

   // Scoreboard, checks before updating so occupancy is the pre-edge one
   always @(posedge clk)
   begin : scoreboard
      int   lane;
      int   exp_lane;
      req_t head;

      if (!rst_n || clear_i)
      begin
         // Queued requests are dropped by the clear
         foreach (sb_q[k])
         begin
            sb_q[k].delete();
         end
         in_fire <= 1'b0;
         rr_exp = '0;
      end
      else
      begin
         in_fire <= in_valid_i && in_grant_o;

         // Grant low exactly when the addressed lane holds FIFO_DEPTH entries
         if (in_valid_i)
         begin
            lane = lane_of(in_addr_i);
            assert (in_grant_o == (sb_q[lane].size() < FIFO_DEPTH))
               else
               begin
                  $display("** Error: in_grant_o = 0x%h, expected 0x%h (lane %0d)", in_grant_o,
                     sb_q[lane].size() < FIFO_DEPTH, lane);
                  err_count++;
               end
         end

         if (out_valid_o && out_grant_i)
         begin
            // First lane holding a request at or after the model pointer
            exp_lane = -1;
            for (int i = 0; i < N_LANES; i++)
            begin
               lane = (int'(rr_exp) + i) % N_LANES;
               if (exp_lane < 0 && sb_q[lane].size() > 0)
               begin
                  exp_lane = lane;
               end
            end
            if (exp_lane >= 0)
            begin
               assert (out_lane_o == LANE_W'(exp_lane))
                  else
                  begin
                     $display("** Error: out_lane_o = 0x%h, expected 0x%h", out_lane_o,
                        LANE_W'(exp_lane));
                     err_count++;
                  end
               // Next turn goes to the lane after the one served
               rr_exp = LANE_W'(exp_lane + 1);
            end

            lane = out_lane_o;
            if (sb_q[lane].size() == 0)
            begin
               $display("** Output on lane %0d with no queued request", lane);
               err_count++;
            end
            else
            begin
               head = sb_q[lane].pop_front();
               assert (out_op_o == head.op && out_addr_o == head.addr
                  && out_wdata_o == head.wdata)
                  else
                  begin
                     $display("** Error: out_op_o/out_addr_o/out_wdata_o = 0x%h/0x%h/0x%h,",
                        out_op_o, out_addr_o, out_wdata_o);
                     $display("   expected 0x%h/0x%h/0x%h", head.op, head.addr, head.wdata);
                     err_count++;
                  end
            end
         end

         if (in_valid_i && in_grant_o)
         begin
            sb_q[lane_of(in_addr_i)].push_back('{in_op_i, in_addr_i, in_wdata_i});
         end
      end
   end

   initial
   begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("** Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
      $display("Simulation failed");
      $finish;
   end

   initial
   begin : main
      bit ok;
      int errs_before;
      int done;
      int issued;
      int cycles;

      rst_n       = 1'b0;
      clear_i     = 1'b0;
      test_mode_i = 1'b0;
      in_op_i     = OP_READ;
      in_addr_i   = '0;
      in_wdata_i  = '0;
      in_valid_i  = 1'b0;
      out_grant_i = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Queue a few requests, clear them, then drain nothing
      errs_before = 0;
      for (int k = 0; k < 3; k++)
      begin
         send_req(make_addr(k % N_LANES), 8, ok);
         check_true(ok, "Request before clear was not accepted");
      end
      clear_i = 1'b1;
      @(negedge clk);
      clear_i     = 1'b0;
      out_grant_i = 1'b1;
      repeat (LEN_CLEAR) @(negedge clk);
      report_test("reset_clear", errs_before);

      // Fill lane 0 under back-pressure
      errs_before = err_count;
      out_grant_i = 1'b0;
      for (int i = 0; i < FIFO_DEPTH; i++)
      begin
         send_req(make_addr(0), 8, ok);
         check_true(ok, "Request to lane 0 was not accepted before it filled");
      end
      send_req(make_addr(0), LEN_BP / 4, ok);
      check_true(!ok, "Request to full lane 0 was accepted");
      send_req(make_addr(1), 8, ok);
      check_true(ok, "Request to lane 1 stalled behind full lane 0");
      report_test("backpressure", errs_before);

      // All lanes full, then drain with grant held high
      errs_before = err_count;
      test_mode_i = 1'b1;
      ok = 1'b1;
      for (int k = 0; k < N_LANES; k++)
      begin
         while (ok && sb_q[k].size() < FIFO_DEPTH)
         begin
            send_req(make_addr(k), 8, ok);
         end
      end
      check_true(ok, "Lane fill stalled before all lanes were full");
      out_grant_i = 1'b1;
      wait_drained(LEN_RR, ok);
      check_true(ok, "Lanes did not drain during round-robin test");
      test_mode_i = 1'b0;
      report_test("round_robin", errs_before);

      // Random valid, payload and output grant
      errs_before = err_count;
      done   = 0;
      issued = 0;
      cycles = 0;
      while (done < RAND_REQS && cycles < RAND_REQS * FIFO_DEPTH * N_LANES)
      begin
         @(negedge clk);
         cycles++;
         if (in_valid_i && in_fire)
         begin
            done++;
            in_valid_i = 1'b0;
         end
         if (!in_valid_i && issued < RAND_REQS && rand_bits(1))
         begin
            in_op_i    = req_op_e'(rand_bits(1));
            in_addr_i  = ADDR_WIDTH'(rand_bits(32));
            in_wdata_i = DATA_WIDTH'(rand_bits(32));
            in_valid_i = 1'b1;
            issued++;
         end
         out_grant_i = rand_bits(1);
      end
      check_true(done == RAND_REQS, "Random traffic stalled before all requests were accepted");
      in_valid_i  = 1'b0;
      out_grant_i = 1'b1;
      wait_drained(N_LANES * FIFO_DEPTH * 4, ok);
      check_true(ok, "Queued requests never appeared at the output");
      report_test("random", errs_before);

      $display("tests ok: %0d, tests failed: %0d, errors: %0d", tests_ok, tests_bad, err_count);
      if (err_count == 0)
      begin
         $display("Simulation passed");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- verilog/req_router_top.sv
`timescale 1ns/1ns

module req_router_top
   import router_cfg_pkg::*;
   import router_types_pkg::*;
#(
   parameter int unsigned N_LANES      = router_cfg_pkg::N_LANES,
   parameter int unsigned ADDR_WIDTH   = router_cfg_pkg::ADDR_WIDTH,
   parameter int unsigned DATA_WIDTH   = router_cfg_pkg::DATA_WIDTH,
   parameter int unsigned FIFO_DEPTH   = router_cfg_pkg::FIFO_DEPTH,
   parameter int unsigned LANE_SEL_LSB = router_cfg_pkg::LANE_SEL_LSB
)
(
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         clear_i,
   input  logic                         test_mode_i,

   // Request input stream
   input  req_op_e                      in_op_i,
   input  logic [ADDR_WIDTH-1:0]        in_addr_i,
   input  logic [DATA_WIDTH-1:0]        in_wdata_i,
   input  logic                         in_valid_i,
   output logic                         in_grant_o,

   // Arbitrated output stream, tagged with its lane
   output req_op_e                      out_op_o,
   output logic [ADDR_WIDTH-1:0]        out_addr_o,
   output logic [DATA_WIDTH-1:0]        out_wdata_o,
   output logic [$clog2(N_LANES)-1:0]   out_lane_o,
   output logic                         out_valid_o,
   input  logic                         out_grant_i
);

   // Packed lane entry: opcode, address, data
   localparam int unsigned REQ_WIDTH = REQ_OP_BITS + ADDR_WIDTH + DATA_WIDTH;

   // Decoder to FIFO, and FIFO to allocator
   lane_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) lane_in  [N_LANES] ();
   lane_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) lane_out [N_LANES] ();

   dest_decoder #(
      .N_LANES      (N_LANES),
      .LANE_SEL_LSB (LANE_SEL_LSB),
      .ADDR_WIDTH   (ADDR_WIDTH),
      .DATA_WIDTH   (DATA_WIDTH)
   ) u_dest_decoder (
      .req_op_i    (in_op_i),
      .req_addr_i  (in_addr_i),
      .req_wdata_i (in_wdata_i),
      .req_valid_i (in_valid_i),
      .req_grant_o (in_grant_o),
      .lanes_o     (lane_in)
   );

   // One FIFO per destination lane
   for (genvar k = 0; k < N_LANES; k++)
   begin : g_lane
      generic_fifo_adv #(
         .DATA_WIDTH (REQ_WIDTH),
         .DATA_DEPTH (FIFO_DEPTH)
      ) u_fifo (
         .clk         (clk),
         .rst_n       (rst_n),
         .clear_i     (clear_i),
         .test_mode_i (test_mode_i),
         .in_i        (lane_in[k]),
         .out_o       (lane_out[k])
      );
   end

   rr_allocator #(
      .N_LANES    (N_LANES),
      .ADDR_WIDTH (ADDR_WIDTH),
      .DATA_WIDTH (DATA_WIDTH)
   ) u_rr_allocator (
      .clk         (clk),
      .rst_n       (rst_n),
      .clear_i     (clear_i),
      .lanes_i     (lane_out),
      .out_op_o    (out_op_o),
      .out_addr_o  (out_addr_o),
      .out_wdata_o (out_wdata_o),
      .out_lane_o  (out_lane_o),
      .out_valid_o (out_valid_o),
      .out_grant_i (out_grant_i)
   );

endmodule

//--- verilog/rr_allocator.sv
`timescale 1ns/1ns

module rr_allocator
   import router_types_pkg::*;
#(
   parameter int unsigned N_LANES    = 4,
   parameter int unsigned ADDR_WIDTH = 32,
   parameter int unsigned DATA_WIDTH = 32
)
(
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         clear_i,
   lane_if.pop                          lanes_i [N_LANES],
   output req_op_e                      out_op_o,
   output logic [ADDR_WIDTH-1:0]        out_addr_o,
   output logic [DATA_WIDTH-1:0]        out_wdata_o,
   output logic [$clog2(N_LANES)-1:0]   out_lane_o,
   output logic                         out_valid_o,
   input  logic                         out_grant_i
);

   localparam int unsigned LANE_W = $clog2(N_LANES);

   // Lane heads flattened for runtime indexing
   req_op_e                lane_op    [N_LANES];
   logic [ADDR_WIDTH-1:0]  lane_addr  [N_LANES];
   logic [DATA_WIDTH-1:0]  lane_wdata [N_LANES];
   logic [N_LANES-1:0]     lane_valid;
   logic [N_LANES-1:0]     lane_grant;

   // Round-robin pointer, highest priority lane
   logic [LANE_W-1:0]      rr_ptr_q;
   logic [LANE_W-1:0]      sel;
   logic                   found;

   for (genvar k = 0; k < N_LANES; k++)
   begin : g_lane
      assign lane_op[k]       = lanes_i[k].op;
      assign lane_addr[k]     = lanes_i[k].addr;
      assign lane_wdata[k]    = lanes_i[k].wdata;
      assign lane_valid[k]    = lanes_i[k].valid;

      // Only the selected lane sees the downstream grant
      assign lane_grant[k]    = out_grant_i && found && (sel == LANE_W'(k));
      assign lanes_i[k].grant = lane_grant[k];
   end

   // First valid lane at or after the pointer
   always_comb
   begin
      logic [LANE_W-1:0] idx;

      found = 1'b0;
      sel   = rr_ptr_q;
      for (int i = 0; i < N_LANES; i++)
      begin
         // Wraps since lane count is a power of two
         idx = rr_ptr_q + LANE_W'(i);
         if (!found && lane_valid[idx])
         begin
            found = 1'b1;
            sel   = idx;
         end
      end
   end

   // Output path straight from the selected head
   assign out_valid_o = found;
   assign out_lane_o  = sel;
   assign out_op_o    = lane_op[sel];
   assign out_addr_o  = lane_addr[sel];
   assign out_wdata_o = lane_wdata[sel];

   // Pointer moves past the lane just served
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rr_ptr_q <= '0;
      end
      else if (clear_i)
      begin
         rr_ptr_q <= '0;
      end
      else if (out_valid_o && out_grant_i)
      begin
         rr_ptr_q <= sel + LANE_W'(1);
      end
   end

   // Lane just served yields to any other waiting lane
   a_no_repeat: assert property (@(posedge clk) disable iff (!rst_n)
      $past(out_valid_o && out_grant_i && !clear_i)
      && ((lane_valid & ~(N_LANES'(1) << $past(sel))) != '0)
      |-> (sel != $past(sel)));

   // Offered lane keeps its request until the output takes it
   a_lane_held: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid_o && !out_grant_i && !clear_i |=> lane_valid[$past(out_lane_o)]);

endmodule

//--- verilog/dest_decoder.sv
`timescale 1ns/1ns

module dest_decoder
   import router_types_pkg::*;
#(
   parameter int unsigned N_LANES      = 4,
   parameter int unsigned LANE_SEL_LSB = 2,
   parameter int unsigned ADDR_WIDTH   = 32,
   parameter int unsigned DATA_WIDTH   = 32
)
(
   input  req_op_e                req_op_i,
   input  logic [ADDR_WIDTH-1:0]  req_addr_i,
   input  logic [DATA_WIDTH-1:0]  req_wdata_i,
   input  logic                   req_valid_i,
   output logic                   req_grant_o,
   lane_if.push                   lanes_o [N_LANES]
);

   localparam int unsigned LANE_W = $clog2(N_LANES);

   // Destination lane from the select field
   logic [LANE_W-1:0]   lane_sel;
   // Per-lane valid and grant gathered into vectors
   logic [N_LANES-1:0]  lane_valid;
   logic [N_LANES-1:0]  lane_grant;

   assign lane_sel = req_addr_i[LANE_SEL_LSB +: LANE_W];

   for (genvar k = 0; k < N_LANES; k++)
   begin : g_lane
      // Payload goes to every lane, valid only to one
      assign lanes_o[k].op    = req_op_i;
      assign lanes_o[k].addr  = req_addr_i;
      assign lanes_o[k].wdata = req_wdata_i;

      assign lane_valid[k]    = req_valid_i && (lane_sel == LANE_W'(k));
      assign lanes_o[k].valid = lane_valid[k];

      assign lane_grant[k]    = lanes_o[k].grant;
   end

   // Grant of the addressed lane only
   // Other lanes may be full without stalling this request
   assign req_grant_o = lane_grant[lane_sel];

   // A valid request lands in exactly one lane, never none or two
   a_one_lane_valid: assert final (!req_valid_i || $onehot(lane_valid))
      else $error("valid request not in exactly one lane: %b", lane_valid);

endmodule

//--- fifo/generic_fifo_adv.sv
`timescale 1ns/1ns

module generic_fifo_adv
   import router_types_pkg::*;
#(
   // Width of one packed entry: opcode, address, data
   parameter int unsigned DATA_WIDTH = 65,
   parameter int unsigned DATA_DEPTH = 4
)
(
   input  logic   clk,
   input  logic   rst_n,
   input  logic   clear_i,
   input  logic   test_mode_i,
   lane_if.pop    in_i,
   lane_if.push   out_o
);

   // Pointer width, one bit minimum for a single entry
   localparam int unsigned PTR_W = (DATA_DEPTH > 1) ? $clog2(DATA_DEPTH) : 1;
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DATA_DEPTH - 1);

   fifo_state_e            state_q;
   fifo_state_e            state_d;

   logic [PTR_W-1:0]       push_ptr_q;
   logic [PTR_W-1:0]       push_ptr_d;
   logic [PTR_W-1:0]       pop_ptr_q;
   logic [PTR_W-1:0]       pop_ptr_d;
   logic [PTR_W-1:0]       push_ptr_inc;
   logic [PTR_W-1:0]       pop_ptr_inc;

   // Entry storage, written on the gated clock
   logic [DATA_WIDTH-1:0]  mem [DATA_DEPTH];
   logic [DATA_WIDTH-1:0]  data_in;
   logic [DATA_WIDTH-1:0]  data_out;

   logic                   grant;
   logic                   valid;
   logic                   push;
   logic                   pop;
   logic                   gate_clock;
   logic                   clk_gated;

   // Handshake outputs come from the state alone
   assign grant = (state_q != FIFO_FULL);
   assign valid = (state_q == FIFO_MIDDLE) || (state_q == FIFO_FULL);

   assign in_i.grant  = grant;
   assign out_o.valid = valid;

   // Completed transfers on each side
   assign push = in_i.valid & grant;
   assign pop  = valid & out_o.grant;

   // Wrapping increments, depth need not be a power of two
   assign push_ptr_inc = (push_ptr_q == LAST_PTR) ? '0 : push_ptr_q + 1'b1;
   assign pop_ptr_inc  = (pop_ptr_q == LAST_PTR) ? '0 : pop_ptr_q + 1'b1;

   // Storage clock only runs on a push
   assign gate_clock = ~push;

   cluster_clock_gating u_cg_cell
   (
      .clk_i     (clk),
      .en_i      (~gate_clock),
      .test_en_i (test_mode_i),
      .clk_o     (clk_gated)
   );

   // Next state and pointers
   always_comb
   begin
      state_d    = state_q;
      push_ptr_d = push_ptr_q;
      pop_ptr_d  = pop_ptr_q;

      case (state_q)
         FIFO_EMPTY:
         begin
            if (push)
            begin
               push_ptr_d = push_ptr_inc;
               // Single-entry FIFO goes straight to full
               state_d    = (push_ptr_inc == pop_ptr_q) ? FIFO_FULL : FIFO_MIDDLE;
            end
         end

         FIFO_MIDDLE:
         begin
            case ({push, pop})
               2'b11:
               begin
                  // Occupancy unchanged
                  push_ptr_d = push_ptr_inc;
                  pop_ptr_d  = pop_ptr_inc;
               end
               2'b10:
               begin
                  push_ptr_d = push_ptr_inc;
                  if (push_ptr_inc == pop_ptr_q)
                  begin
                     state_d = FIFO_FULL;
                  end
               end
               2'b01:
               begin
                  pop_ptr_d = pop_ptr_inc;
                  if (pop_ptr_inc == push_ptr_q)
                  begin
                     state_d = FIFO_EMPTY;
                  end
               end
               default:
               begin
                  state_d = FIFO_MIDDLE;
               end
            endcase
         end

         FIFO_FULL:
         begin
            // No push here, grant is low
            if (pop)
            begin
               pop_ptr_d = pop_ptr_inc;
               state_d   = FIFO_MIDDLE;
            end
         end

         default:
         begin
            // Unused encoding
            state_d    = FIFO_EMPTY;
            push_ptr_d = '0;
            pop_ptr_d  = '0;
         end
      endcase
   end

   // Control registers
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q    <= FIFO_EMPTY;
         push_ptr_q <= '0;
         pop_ptr_q  <= '0;
      end
      else if (clear_i)
      begin
         state_q    <= FIFO_EMPTY;
         push_ptr_q <= '0;
         pop_ptr_q  <= '0;
      end
      else
      begin
         state_q    <= state_d;
         push_ptr_q <= push_ptr_d;
         pop_ptr_q  <= pop_ptr_d;
      end
   end

   // Pack opcode on top of address and data
   assign data_in = {in_i.op, in_i.addr, in_i.wdata};

   always_ff @(posedge clk_gated)
   begin
      if (push)
      begin
         mem[push_ptr_q] <= data_in;
      end
   end

   // Head entry, unpacked onto the output lane
   assign data_out = mem[pop_ptr_q];
   assign out_o.op = req_op_e'(data_out[DATA_WIDTH-REQ_OP_BITS]);
   assign {out_o.addr, out_o.wdata} = data_out[DATA_WIDTH-REQ_OP_BITS-1:0];

   // Grant withheld only once the write slot has wrapped onto the head
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      !in_i.grant |-> (push_ptr_q == pop_ptr_q));

   // Nothing offered downstream only while no entry is stored
   a_no_valid_empty: assert property (@(posedge clk) disable iff (!rst_n)
      !out_o.valid |-> (push_ptr_q == pop_ptr_q));

   // Stalled head keeps valid and payload until taken
   a_head_stable: assert property (@(posedge clk) disable iff (!rst_n)
      out_o.valid && !out_o.grant && !clear_i |=> out_o.valid && $stable(data_out));

endmodule

//--- verilog/cluster_clock_gating.sv
`timescale 1ns/1ns

module cluster_clock_gating
(
   input  logic clk_i,
   input  logic en_i,
   input  logic test_en_i,
   output logic clk_o
);

   // Enable as seen by the AND gate
   logic en_latched;

   // Transparent while the clock is low
   // Enable settles before the rising edge, so no glitch on clk_o
   always_latch
   begin
      if (!clk_i)
      begin
         // Test mode forces the clock on for scan
         en_latched <= en_i | test_en_i;
      end
   end

   // Gated clock
   assign clk_o = clk_i & en_latched;

endmodule

//--- common/lane_if.sv
`timescale 1ns/1ns

interface lane_if
   import router_types_pkg::*;
#(
   parameter int unsigned ADDR_WIDTH = 32,
   parameter int unsigned DATA_WIDTH = 32
);

   // Request payload
   req_op_e                op;
   logic [ADDR_WIDTH-1:0]  addr;
   logic [DATA_WIDTH-1:0]  wdata;

   // Valid/grant handshake
   // Transfer on a rising edge with both high
   logic                   valid;
   logic                   grant;

   // Request source side
   // Holds valid and payload until granted
   modport push
   (
      output op,
      output addr,
      output wdata,
      output valid,
      input  grant
   );

   // Request sink side
   // May raise grant without valid
   modport pop
   (
      input  op,
      input  addr,
      input  wdata,
      input  valid,
      output grant
   );

endinterface

//--- common/router_types_pkg.sv
package router_types_pkg;

   // Lane FIFO controller state
   // EMPTY has no valid entry, FULL withholds grant
   typedef enum logic [1:0]
   {
      FIFO_EMPTY  = 2'b00,
      FIFO_MIDDLE = 2'b01,
      FIFO_FULL   = 2'b10
   } fifo_state_e;

   // Request opcode
   // Write data is carried on reads too but has no meaning there
   typedef enum logic
   {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } req_op_e;

   // Opcode is the top bit of a stored lane entry
   // Address and data follow below it
   localparam int unsigned REQ_OP_BITS = $bits(req_op_e);

endpackage

//--- common/router_cfg_pkg.sv
package router_cfg_pkg;

   // Default router geometry
   // Each value is only a default for a top-level parameter

   // Number of FIFO lanes
   // Power of two and at least two, the select field is log2 wide
   localparam int unsigned N_LANES = 4;

   // Request address width in bits
   localparam int unsigned ADDR_WIDTH = 32;

   // Write data width in bits
   localparam int unsigned DATA_WIDTH = 32;

   // Entries held by one lane FIFO
   localparam int unsigned FIFO_DEPTH = 4;

   // Lowest address bit of the lane select field
   // Bit 2 interleaves consecutive 32-bit words across lanes
   localparam int unsigned LANE_SEL_LSB = 2;

endpackage
